// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_decode_stage
FILELIST = sim.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: sim.f
+incdir+verilog
verilog/arm_isa_pkg.sv
verilog/decode_flow_pkg.sv
verilog/insn_queue.sv
verilog/insn_classifier.sv
verilog/reg_file.sv
verilog/barrel_shifter.sv
verilog/imm_expander.sv
verilog/operand_select.sv
verilog/decode_stage.sv
test/tb_decode_stage.sv

// File: test/tb_decode_stage.sv
`timescale 1ns/1ps

`include "decode_settings.svh"

module tb_decode_stage
	import arm_isa_pkg::*;
();

	// instructions sent by each test group
	localparam int N_ALU_IMM = 32;
	localparam int N_SHIFT = 96;
	localparam int N_R15 = 4;
	localparam int N_OTHER = 36;
	// two more than the stage can hold, so fetch has to wait for credits
	localparam int N_BP = `DEC_QUEUE_DEPTH + `DEC_OUT_CREDITS + 2;
	localparam int N_RAND = 40;
	localparam int N_TOTAL = N_ALU_IMM + N_SHIFT + N_R15 + N_OTHER + N_BP + N_RAND;

	typedef struct packed {
		insn_class_t cls;
		word_t o0;
		word_t o1;
		word_t o2;
		logic cy;
	} bundle_t;

	logic clk = 1'b0;
	logic arst_n;
	logic insn_valid;
	word_t insn;
	word_t pc;
	logic cpsr_c;
	logic wr_en;
	reg_idx_t wr_idx;
	word_t wr_data;
	logic op_credit = 1'b0;
	logic insn_credit;
	logic op_valid;
	insn_class_t op_class;
	word_t op0;
	word_t op1;
	word_t op2;
	logic carry;

	integer seed = 32'hdfcbc229;
	word_t shadow [`DEC_NUM_REGS];
	bundle_t exp_q [$];
	bundle_t got;
	word_t next_pc = 32'h0000_1000;
	logic cpsr_tb = 1'b0;
	logic hold = 1'b0;
	logic starved = 1'b0;
	int sent = 0;
	int fcred_back = 0;
	int valid_seen = 0;
	int credits_seen = 0;
	int credits_given = 0;
	int errors = 0;
	int end_errors = 0;

	decode_stage u_dut (
		.clk(clk), .arst_n(arst_n), .insn_valid(insn_valid), .insn(insn), .pc(pc),
		.cpsr_c(cpsr_c), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.op_credit(op_credit), .insn_credit(insn_credit), .op_valid(op_valid),
		.op_class(op_class), .op0(op0), .op1(op1), .op2(op2), .carry(carry)
	);

	always #10 clk = ~clk;

	function automatic word_t rnd();
		return $random(seed);
	endfunction

	// register read as the stage sees it, r15 is the adjusted address
	function automatic word_t rd(logic [3:0] idx, word_t r15v);
		return (idx == 4'd15) ? r15v : shadow[idx];
	endfunction

	function automatic word_t rot_imm(word_t w);
		logic [63:0] t;
		t = {24'd0, w[7:0], 24'd0, w[7:0]} >> (2 * int'(w[11:8]));
		return t[31:0];
	endfunction

	// operand 2 shifter, carry in bit 32
	function automatic logic [32:0] shift_model(word_t w, word_t v, word_t rs, logic cin);
		logic [63:0] t;
		int n;
		logic [1:0] k;
		k = w[6:5];
		if (w[4]) begin
			n = int'(rs[7:0]);
			if (n == 0)
				return {cin, v};
			if (k == 2'd3) begin
				n = n % 32;
				if (n == 0)
					return {v[31], v};
			end else if (n > 32) begin
				return (k == 2'd2) ? {v[31], {32{v[31]}}} : 33'd0;
			end
		end else begin
			n = int'(w[11:7]);
			if (n == 0) begin
				if (k == 2'd0)
					return {cin, v};
				if (k == 2'd3)
					return {v[0], cin, v[31:1]};
				n = 32;
			end
		end
		case (k)
			2'd0: begin
				t = {32'd0, v} << n;
				return {t[32], t[31:0]};
			end
			2'd1: begin
				t = {v, 32'd0} >> n;
				return {t[31], t[63:32]};
			end
			2'd2: begin
				t = $signed({v, 32'd0}) >>> n;
				return {t[31], t[63:32]};
			end
			default: begin
				t = {v, v} >> n;
				return {t[31], t[31:0]};
			end
		endcase
	endfunction

	// expected bundle from the operand rules, then hand the word to the queue
	task automatic issue(word_t w, insn_class_t cls);
		word_t a;
		word_t r8;
		word_t rv;
		logic [32:0] sh;
		bundle_t e;
		a = next_pc;
		next_pc = next_pc + 32'd4;
		r8 = a + 32'd8;
		rv = (cls == alu && !w[25] && w[4]) ? a + 32'd12 : r8;
		e = '{cls: cls, o0: '0, o1: '0, o2: '0, cy: cpsr_tb};
		case (cls)
			mult: begin
				e.o0 = rd(w[15:12], r8);
				e.o1 = rd(w[3:0], r8);
				e.o2 = rd(w[11:8], r8);
			end
			msr, bx: e.o0 = rd(w[3:0], r8);
			msr_flags: e.o0 = w[25] ? rot_imm(w) : rd(w[3:0], r8);
			swp, hdata_reg: begin
				e.o0 = rd(w[19:16], r8);
				e.o1 = rd(w[3:0], r8);
			end
			hdata_imm: begin
				e.o0 = rd(w[19:16], r8);
				e.o1 = {24'd0, w[11:8], w[3:0]};
			end
			alu, ldrstr: begin
				e.o0 = rd(w[19:16], rv);
				if (w[25]) begin
					e.o1 = (cls == alu) ? rot_imm(w) : {20'd0, w[11:0]};
				end else begin
					sh = shift_model(w, rd(w[3:0], rv), rd(w[11:8], rv), cpsr_tb);
					e.o1 = sh[31:0];
					e.cy = sh[32];
				end
			end
			ldmstm: begin
				e.o0 = rd(w[19:16], r8);
				e.o1 = {16'd0, w[15:0]};
			end
			branch: e.o0 = {{6{w[23]}}, w[23:0], 2'b00};
			ldcstc: begin
				e.o0 = rd(w[19:16], r8);
				e.o1 = {24'd0, w[7:0]};
			end
			mrcmcr: e.o0 = rd(w[15:12], r8);
			default: begin
			end
		endcase
		@(posedge clk);
		// fetch may only push while it holds a credit
		while (`DEC_QUEUE_DEPTH + fcred_back - sent <= 0) begin
			starved = 1'b1;
			@(posedge clk);
		end
		exp_q.push_back(e);
		sent++;
		insn_valid <= 1'b1;
		insn <= w;
		pc <= a;
		@(posedge clk);
		insn_valid <= 1'b0;
	endtask

	task automatic drain();
		@(posedge clk);
		while (exp_q.size() != 0 || valid_seen != credits_given)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	// only called with nothing in flight
	task automatic write_reg(logic [3:0] idx, word_t data);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_idx <= idx;
		wr_data <= data;
		shadow[idx] = data;
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic set_carry(logic c);
		@(posedge clk);
		cpsr_c <= c;
		cpsr_tb = c;
	endtask

	task automatic alu_imm(logic [3:0] rn, logic [3:0] rot, logic [7:0] imm);
		issue({4'he, 3'b001, 1'b0, 3'(rnd()), 1'(rnd()), rn, 4'(rnd()), rot, imm}, alu);
	endtask

	task automatic alu_shift_imm(logic [3:0] rn, logic [4:0] amt, logic [1:0] k, logic [3:0] rm);
		issue({4'he, 3'b000, 1'b0, 3'(rnd()), 1'(rnd()), rn, 4'(rnd()), amt, k, 1'b0, rm},
			alu);
	endtask

	task automatic alu_shift_reg(logic [3:0] rn, logic [3:0] rs, logic [1:0] k, logic [3:0] rm);
		issue({4'he, 3'b000, 1'b0, 3'(rnd()), 1'(rnd()), rn, 4'(rnd()), rs, 1'b0, k, 1'b1, rm},
			alu);
	endtask

	// one instruction of every non alu class
	task automatic other_classes();
		logic [1:0] sh;
		sh = {1'(rnd()), 1'b1};
		issue({4'he, 6'b000000, 2'(rnd()), 4'(rnd()), 4'(rnd()), 4'(rnd()), 4'b1001,
			4'(rnd())}, mult);
		issue({4'he, 5'b00010, 1'(rnd()), 2'b00, 4'hf, 4'(rnd()), 12'h000}, mrs);
		issue({4'he, 5'b00010, 1'(rnd()), 2'b10, 4'h9, 4'hf, 8'h00, 4'(rnd())}, msr);
		issue({4'he, 2'b00, 1'b1, 1'b1, 1'b0, 1'(rnd()), 2'b10, 4'h8, 4'hf, 12'(rnd())},
			msr_flags);
		issue({4'he, 2'b00, 1'b0, 1'b1, 1'b0, 1'(rnd()), 2'b10, 4'h8, 4'hf, 8'h00, 4'(rnd())},
			msr_flags);
		issue({4'he, 5'b00010, 1'(rnd()), 2'b00, 4'(rnd()), 4'(rnd()), 8'h09, 4'(rnd())}, swp);
		issue({4'he, 24'h12fff1, 4'(rnd())}, bx);
		issue({4'he, 3'b000, 1'b1, 1'(rnd()), 1'b0, 1'(rnd()), 1'b1, 4'(rnd()), 4'(rnd()),
			4'b0000, 1'b1, sh, 1'b1, 4'(rnd())}, hdata_reg);
		issue({4'he, 3'b000, 1'b1, 1'(rnd()), 1'b1, 1'(rnd()), 1'b1, 4'(rnd()), 4'(rnd()),
			4'(rnd()), 1'b1, sh, 1'b1, 4'(rnd())}, hdata_imm);
		issue({4'he, 3'b011, 5'(rnd()), 4'(rnd()), 4'(rnd()), 7'(rnd()), 1'b0, 4'(rnd())},
			ldrstr);
		issue({4'he, 3'b010, 5'(rnd()), 4'(rnd()), 4'(rnd()), 5'(rnd()), 2'(rnd()), 1'b0,
			4'(rnd())}, ldrstr);
		issue({4'he, 3'b100, 5'(rnd()), 4'(rnd()), 16'(rnd())}, ldmstm);
		// negative offset
		issue({4'he, 3'b101, 1'(rnd()), 1'b1, 23'(rnd())}, branch);
		issue({4'he, 3'b110, 5'(rnd()), 4'(rnd()), 16'(rnd())}, ldcstc);
		issue({4'he, 4'b1110, 16'(rnd()), 3'(rnd()), 1'b0, 4'(rnd())}, cdp);
		issue({4'he, 4'b1110, 16'(rnd()), 3'(rnd()), 1'b1, 4'(rnd())}, mrcmcr);
		issue({4'he, 4'hf, 24'(rnd())}, swi);
		issue({4'he, 3'b011, 20'(rnd()), 1'b1, 4'(rnd())}, undefined);
	endtask

	task automatic check_word(string what, word_t g, word_t e);
		assert (g == e) else begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, g, e);
			errors++;
		end
	endtask

	// outputs are sampled in the middle of the cycle
	always @(negedge clk) begin
		if (!arst_n) begin
			assert (!op_valid && !insn_credit) else begin
				$display("Output handshake active during reset");
				errors++;
			end
		end else begin
			if (insn_credit)
				fcred_back++;
			if (op_valid) begin
				assert (valid_seen < `DEC_OUT_CREDITS + credits_seen) else begin
					$display("Bundle sent with no output credit left");
					errors++;
				end
				valid_seen++;
				if (exp_q.size() == 0) begin
					$display("Bundle arrived with no instruction outstanding");
					errors++;
				end else begin
					got = exp_q.pop_front();
					assert (op_class == got.cls) else begin
						$display("[FAIL] %0t: class is %0d, expected %0d", $time,
							op_class, got.cls);
						errors++;
					end
					check_word("op0", op0, got.o0);
					check_word("op1", op1, got.o1);
					check_word("op2", op2, got.o2);
					assert (carry == got.cy) else begin
						$display("[FAIL] %0t: carry is %b, expected %b", $time, carry, got.cy);
						errors++;
					end
				end
			end
			if (op_credit)
				credits_seen++;
		end
	end

	// execute hands a credit back for each bundle unless it is stalled
	always @(posedge clk) begin
		if (!arst_n) begin
			op_credit <= 1'b0;
		end else if (!hold && valid_seen > credits_given) begin
			op_credit <= 1'b1;
			credits_given++;
		end else begin
			op_credit <= 1'b0;
		end
	end

	initial begin
		repeat (40 * N_TOTAL + 200) @(posedge clk);
		$display("Timeout: the decode stage stopped delivering bundles");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		cpsr_c = 1'b0;
		wr_en = 1'b0;
		wr_idx = '0;
		wr_data = '0;
		for (int i = 0; i < `DEC_NUM_REGS; i++)
			shadow[i] = '0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < 15; i++)
			write_reg(4'(i), rnd());

		// rotated immediates
		for (int r = 0; r < 16; r++) begin
			alu_imm(4'(rnd() % 15), 4'(r), 8'(rnd()));
			alu_imm(4'(rnd() % 15), 4'(r), 8'h81);
		end
		drain();

		// each shift kind, amounts from the instruction and from r9
		for (int c = 0; c < 2; c++) begin
			set_carry(1'(c));
			write_reg(4'd3, (c == 0) ? 32'h8000_0001 : 32'h7fff_fffe);
			for (int k = 0; k < 4; k++) begin
				alu_shift_imm(4'd2, 5'd0, 2'(k), 4'd3);
				alu_shift_imm(4'd2, 5'd1, 2'(k), 4'd3);
				alu_shift_imm(4'd2, 5'd16, 2'(k), 4'd3);
				alu_shift_imm(4'd2, 5'd31, 2'(k), 4'd3);
				for (int i = 0; i < 8; i++) begin
					drain();
					write_reg(4'd9, {24'(rnd()),
						(i == 0) ? 8'd0 : (i == 1) ? 8'd1 : (i == 2) ? 8'd4 :
						(i == 3) ? 8'd31 : (i == 4) ? 8'd32 : (i == 5) ? 8'd33 :
						(i == 6) ? 8'd64 : 8'd200});
					alu_shift_reg(4'd2, 4'd9, 2'(k), 4'd3);
				end
			end
			drain();
		end

		// r15 as a source
		alu_imm(4'd15, 4'd0, 8'h00);
		alu_shift_imm(4'd15, 5'd0, 2'd0, 4'd15);
		alu_shift_reg(4'd15, 4'd15, 2'd0, 4'd15);
		issue({4'he, 3'b010, 5'b11001, 4'd15, 4'd0, 5'd0, 2'd0, 1'b0, 4'd15}, ldrstr);
		drain();

		for (int i = 0; i < 2; i++) begin
			set_carry(1'(i));
			other_classes();
		end
		drain();

		// execute stalls, the queue fills and fetch runs dry
		hold = 1'b1;
		fork
			for (int i = 0; i < N_BP; i++)
				alu_imm(4'(rnd() % 15), 4'(rnd()), 8'(rnd()));
			begin
				// wait until fetch spends its last credit, then keep execute stalled
				while (`DEC_QUEUE_DEPTH + fcred_back - sent != 0)
					@(posedge clk);
				repeat (10 + (rnd() % 30)) @(posedge clk);
				assert (`DEC_QUEUE_DEPTH + fcred_back - sent == 0 &&
					exp_q.size() == `DEC_QUEUE_DEPTH) else begin
					$display("Queue did not fill while execute was stalled");
					end_errors++;
				end
				@(negedge clk);
				hold = 1'b0;
			end
		join
		drain();

		for (int i = 0; i < N_RAND; i++) begin
			case (rnd() % 3)
				0: alu_imm(4'(rnd()), 4'(rnd()), 8'(rnd()));
				1: alu_shift_imm(4'(rnd()), 5'(rnd()), 2'(rnd()), 4'(rnd()));
				default: alu_shift_reg(4'(rnd()), 4'(rnd()), 2'(rnd()), 4'(rnd()));
			endcase
		end
		drain();
		repeat (5) @(posedge clk);

		assert (fcred_back == sent && valid_seen == sent) else begin
			$display("Credit or bundle totals do not match the instructions sent");
			end_errors++;
		end
		assert (starved) else begin
			$display("Fetch never ran out of credits");
			end_errors++;
		end

		$display("Sent %0d instructions, %0d bundles, %0d errors", sent, valid_seen,
			errors + end_errors);
		if (errors + end_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog/arm_isa_pkg.sv
package arm_isa_pkg;

	`include "decode_settings.svh"

	// data word, also used for addresses
	typedef logic [31:0] word_t;

	// register number as encoded in the instruction
	typedef logic [$clog2(`DEC_NUM_REGS)-1:0] reg_idx_t;

	// instruction classes, in the order the decoder tests them
	typedef enum logic [4:0] {
		mult,
		mrs,
		msr,
		msr_flags,
		swp,
		bx,
		hdata_reg,
		hdata_imm,
		alu,
		undefined,
		ldrstr,
		ldmstm,
		branch,
		ldcstc,
		cdp,
		mrcmcr,
		swi,
		unknown
	} insn_class_t;

	// operand 2 shift kind, bits 6:5 of the instruction
	typedef enum logic [1:0] {
		lsl = 2'b00,
		lsr = 2'b01,
		asr = 2'b10,
		ror = 2'b11
	} shift_kind_t;

endpackage

// File: verilog/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter
	import arm_isa_pkg::*;
(
	input  word_t insn,
	input  word_t operand,
	input  word_t reg_amt,
	input  logic  carry_in,
	output word_t result,
	output logic  carry_out
);

	shift_kind_t kind;
	logic [7:0] amt8;
	logic [4:0] imm5;
	logic [5:0] amt;
	logic by_reg;
	logic ext_space;
	logic rrx;
	logic left;
	logic fill;
	word_t src;
	word_t data;
	word_t shifted;
	logic c;

	assign kind = shift_kind_t'(insn[6:5]);
	assign by_reg = insn[4];
	// multiply, swap and halfword forms pass rm through untouched
	assign ext_space = insn[4] & insn[7];
	assign amt8 = reg_amt[7:0];
	assign imm5 = insn[11:7];
	assign rrx = (kind == ror) && !by_reg && (imm5 == 5'd0);
	assign left = (kind == lsl);
	assign fill = (kind == asr) && operand[31];

	// effective amount, 0..33
	always_comb begin
		if (ext_space)
			amt = 6'd0;
		else if (by_reg && kind == ror)
			// nonzero multiple of 32 keeps the word, carry from bit 31
			amt = (amt8 != 8'd0 && amt8[4:0] == 5'd0) ? 6'd32 : {1'b0, amt8[4:0]};
		else if (by_reg)
			// 33 is enough to empty both the word and the carry
			amt = (amt8 > 8'd32) ? 6'd33 : amt8[5:0];
		else if (imm5 == 5'd0 && (kind == lsr || kind == asr))
			amt = 6'd32;
		else
			amt = {1'b0, imm5};
	end

	// right shifter with carry riding along; lsl uses it on the reversed word
	always_comb begin
		for (int i = 0; i < 32; i++)
			src[i] = left ? operand[31 - i] : operand[i];
		data = src;
		c = carry_in;
		for (int k = 0; k < 6; k++) begin
			if (amt[k]) begin
				c = data[(1 << k) - 1];
				data = (data >> (1 << k)) |
					((kind == ror) ? (data << (32 - (1 << k))) :
					(fill ? ~(32'hffff_ffff >> (1 << k)) : 32'd0));
			end
		end
		for (int i = 0; i < 32; i++)
			shifted[i] = left ? data[31 - i] : data[i];
	end

	always_comb begin
		if (rrx) begin
			result = {carry_in, operand[31:1]};
			carry_out = operand[0];
		end else begin
			result = shifted;
			carry_out = c;
		end
	end

endmodule

// File: verilog/decode_flow_pkg.sv
package decode_flow_pkg;

	`include "decode_settings.svh"

	// read and write index into the instruction queue
	typedef logic [$clog2(`DEC_QUEUE_DEPTH)-1:0] qptr_t;

	// occupancy, one extra bit so a full queue is distinct from empty
	typedef logic [$clog2(`DEC_QUEUE_DEPTH):0] qcount_t;

	// credits held toward execute
	typedef logic [$clog2(`DEC_OUT_CREDITS+1)-1:0] credit_t;

endpackage

// File: verilog/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// instruction queue entries
// fetch starts with this many credits, keep it a power of two
`define DEC_QUEUE_DEPTH 4

// bundles execute can take right after reset
`define DEC_OUT_CREDITS 2

// architectural registers, r15 is the pc
`define DEC_NUM_REGS 16

`endif

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
	import arm_isa_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        insn_valid,
	input  word_t       insn,
	input  word_t       pc,
	input  logic        cpsr_c,
	input  logic        wr_en,
	input  reg_idx_t    wr_idx,
	input  word_t       wr_data,
	input  logic        op_credit,
	output logic        insn_credit,
	output logic        op_valid,
	output insn_class_t op_class,
	output word_t       op0,
	output word_t       op1,
	output word_t       op2,
	output logic        carry
);

	word_t head_insn;
	word_t head_pc;
	logic empty;
	logic pop;
	insn_class_t insn_class;
	reg_idx_t rd_idx0;
	reg_idx_t rd_idx1;
	reg_idx_t rd_idx2;
	word_t r15_value;
	word_t rd_data0;
	word_t rd_data1;
	word_t rd_data2;
	word_t shift_result;
	logic shift_carry;
	word_t rot_imm;
	word_t fixed_imm;

	insn_queue u_queue (
		.clk(clk), .arst_n(arst_n),
		.push(insn_valid), .push_insn(insn), .push_pc(pc),
		.pop(pop), .head_insn(head_insn), .head_pc(head_pc),
		.empty(empty), .insn_credit(insn_credit)
	);

	// everything below works on the queue head in the same cycle
	insn_classifier u_classifier (
		.insn(head_insn), .pc(head_pc), .insn_class(insn_class),
		.rd_idx0(rd_idx0), .rd_idx1(rd_idx1), .rd_idx2(rd_idx2),
		.r15_value(r15_value)
	);

	reg_file u_regs (
		.clk(clk), .arst_n(arst_n),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.rd_idx0(rd_idx0), .rd_idx1(rd_idx1), .rd_idx2(rd_idx2),
		.r15_value(r15_value),
		.rd_data0(rd_data0), .rd_data1(rd_data1), .rd_data2(rd_data2)
	);

	// rm is shifted by rs or by the immediate amount
	barrel_shifter u_shifter (
		.insn(head_insn), .operand(rd_data1), .reg_amt(rd_data2),
		.carry_in(cpsr_c), .result(shift_result), .carry_out(shift_carry)
	);

	imm_expander u_imm (
		.insn(head_insn), .rot_imm(rot_imm), .fixed_imm(fixed_imm)
	);

	operand_select u_select (
		.clk(clk), .arst_n(arst_n),
		.insn_class(insn_class), .insn(head_insn), .cpsr_c(cpsr_c),
		.empty(empty), .rd_data0(rd_data0), .rd_data2(rd_data2),
		.shift_result(shift_result), .shift_carry(shift_carry),
		.rot_imm(rot_imm), .fixed_imm(fixed_imm), .op_credit(op_credit),
		.pop(pop), .op_valid(op_valid), .op_class(op_class),
		.op0(op0), .op1(op1), .op2(op2), .carry(carry)
	);

endmodule

// File: verilog/imm_expander.sv
`timescale 1ns/1ps

module imm_expander
	import arm_isa_pkg::*;
(
	input  word_t insn,
	output word_t rot_imm,
	output word_t fixed_imm
);

	logic [3:0] rot;
	word_t base;
	word_t by16;
	word_t by8;
	word_t by4;

	// imm8 rotated right by twice the 4-bit field
	assign rot = insn[11:8];
	assign base = {24'd0, insn[7:0]};

	assign by16 = rot[3] ? {base[15:0], base[31:16]} : base;
	assign by8 = rot[2] ? {by16[7:0], by16[31:8]} : by16;
	assign by4 = rot[1] ? {by8[3:0], by8[31:4]} : by8;
	assign rot_imm = rot[0] ? {by4[1:0], by4[31:2]} : by4;

	// the field each major opcode group carries
	always_comb begin
		case (insn[27:25])
			// halfword offset split around the sh bits
			3'b000:
				fixed_imm = {24'd0, insn[11:8], insn[3:0]};
			3'b010, 3'b011:
				fixed_imm = {20'd0, insn[11:0]};
			// ldm/stm register list
			3'b100:
				fixed_imm = {16'd0, insn[15:0]};
			// word offset, sign extended
			3'b101:
				fixed_imm = {{6{insn[23]}}, insn[23:0], 2'b00};
			default:
				fixed_imm = {24'd0, insn[7:0]};
		endcase
	end

endmodule

// File: verilog/insn_classifier.sv
`timescale 1ns/1ps

module insn_classifier
	import arm_isa_pkg::*;
(
	input  word_t       insn,
	input  word_t       pc,
	output insn_class_t insn_class,
	output reg_idx_t    rd_idx0,
	output reg_idx_t    rd_idx1,
	output reg_idx_t    rd_idx2,
	output word_t       r15_value
);

	always_comb begin
		insn_class = undefined;
		// unused read ports look at r0
		rd_idx0 = '0;
		rd_idx1 = '0;
		rd_idx2 = '0;

		// first match wins, multiply sits inside the alu space so it goes first
		casez (insn)
			32'b????_0000_00??_????_????_????_1001_????: begin
				insn_class = mult;
				rd_idx0 = insn[15:12];
				rd_idx1 = insn[3:0];
				rd_idx2 = insn[11:8];
			end
			32'b????_0001_0?00_1111_????_0000_0000_0000:
				insn_class = mrs;
			32'b????_0001_0?10_1001_1111_0000_0000_????: begin
				insn_class = msr;
				rd_idx0 = insn[3:0];
			end
			32'b????_00?1_0?10_1000_1111_????_????_????: begin
				insn_class = msr_flags;
				rd_idx0 = insn[3:0];
			end
			// swap before halfword, the register halfword pattern also covers it
			32'b????_0001_0?00_????_????_0000_1001_????: begin
				insn_class = swp;
				rd_idx0 = insn[19:16];
				rd_idx1 = insn[3:0];
			end
			32'b????_0001_0010_1111_1111_1111_0001_????: begin
				insn_class = bx;
				rd_idx0 = insn[3:0];
			end
			32'b????_000?_?0??_????_????_0000_1??1_????: begin
				insn_class = hdata_reg;
				rd_idx0 = insn[19:16];
				rd_idx1 = insn[3:0];
			end
			32'b????_000?_?1??_????_????_????_1??1_????: begin
				insn_class = hdata_imm;
				rd_idx0 = insn[19:16];
			end
			32'b????_00??_????_????_????_????_????_????: begin
				// bits 7 and 4 both set with a register operand is extension space
				if (!insn[25] && insn[7] && insn[4]) begin
					insn_class = undefined;
				end else begin
					insn_class = alu;
					rd_idx0 = insn[19:16];
					rd_idx1 = insn[3:0];
					rd_idx2 = insn[11:8];
				end
			end
			32'b????_011?_????_????_????_????_???1_????:
				insn_class = undefined;
			32'b????_01??_????_????_????_????_????_????: begin
				insn_class = ldrstr;
				rd_idx0 = insn[19:16];
				rd_idx1 = insn[3:0];
			end
			32'b????_100?_????_????_????_????_????_????: begin
				insn_class = ldmstm;
				rd_idx0 = insn[19:16];
			end
			32'b????_101?_????_????_????_????_????_????:
				insn_class = branch;
			32'b????_110?_????_????_????_????_????_????: begin
				insn_class = ldcstc;
				rd_idx0 = insn[19:16];
			end
			32'b????_1110_????_????_????_????_???0_????:
				insn_class = cdp;
			32'b????_1110_????_????_????_????_???1_????: begin
				insn_class = mrcmcr;
				rd_idx0 = insn[15:12];
			end
			32'b????_1111_????_????_????_????_????_????:
				insn_class = swi;
			default:
				insn_class = undefined;
		endcase

		// pc reads one word further when the shift amount comes from a register
		if (insn_class == alu && !insn[25] && insn[4])
			r15_value = pc + 32'd12;
		else
			r15_value = pc + 32'd8;
	end

endmodule

// File: verilog/insn_queue.sv
`timescale 1ns/1ps

`include "decode_settings.svh"

module insn_queue
	import arm_isa_pkg::*;
	import decode_flow_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  push,
	input  word_t push_insn,
	input  word_t push_pc,
	input  logic  pop,
	output word_t head_insn,
	output word_t head_pc,
	output logic  empty,
	output logic  insn_credit
);

	// instruction and its address stored side by side
	word_t insn_mem [`DEC_QUEUE_DEPTH];
	word_t pc_mem [`DEC_QUEUE_DEPTH];

	qptr_t wr_ptr;
	qptr_t rd_ptr;
	qcount_t count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == qcount_t'(`DEC_QUEUE_DEPTH));
	assign empty = (count == '0);
	// a push while full breaks the credit protocol, drop it
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign head_insn = insn_mem[rd_ptr];
	assign head_pc = pc_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			insn_mem[wr_ptr] <= push_insn;
			pc_mem[wr_ptr] <= push_pc;
		end
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			insn_credit <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			// one credit back to fetch for each freed entry
			insn_credit <= do_pop;
		end
	end

endmodule

// File: verilog/operand_select.sv
`timescale 1ns/1ps

`include "decode_settings.svh"

module operand_select
	import arm_isa_pkg::*;
	import decode_flow_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  insn_class_t insn_class,
	input  word_t       insn,
	input  logic        cpsr_c,
	input  logic        empty,
	input  word_t       rd_data0,
	input  word_t       rd_data2,
	input  word_t       shift_result,
	input  logic        shift_carry,
	input  word_t       rot_imm,
	input  word_t       fixed_imm,
	input  logic        op_credit,
	output logic        pop,
	output logic        op_valid,
	output insn_class_t op_class,
	output word_t       op0,
	output word_t       op1,
	output word_t       op2,
	output logic        carry
);

	credit_t credits;
	word_t op0_d;
	word_t op1_d;
	word_t op2_d;
	logic carry_d;

	// take the head only if execute has room for it
	assign pop = !empty && (credits != '0);

	always_comb begin
		op0_d = '0;
		op1_d = '0;
		op2_d = '0;
		carry_d = cpsr_c;
		case (insn_class)
			// rm reaches op1 through the shifter unshifted
			mult: begin
				op0_d = rd_data0;
				op1_d = shift_result;
				op2_d = rd_data2;
			end
			msr, bx, mrcmcr:
				op0_d = rd_data0;
			msr_flags:
				op0_d = insn[25] ? rot_imm : rd_data0;
			swp, hdata_reg: begin
				op0_d = rd_data0;
				op1_d = shift_result;
			end
			hdata_imm, ldmstm, ldcstc: begin
				op0_d = rd_data0;
				op1_d = fixed_imm;
			end
			alu: begin
				op0_d = rd_data0;
				if (insn[25]) begin
					op1_d = rot_imm;
				end else begin
					op1_d = shift_result;
					carry_d = shift_carry;
				end
			end
			ldrstr: begin
				op0_d = rd_data0;
				if (insn[25]) begin
					op1_d = fixed_imm;
				end else begin
					op1_d = shift_result;
					carry_d = shift_carry;
				end
			end
			branch:
				op0_d = fixed_imm;
			// mrs, cdp, swi and undefined leave everything zero
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= credit_t'(`DEC_OUT_CREDITS);
			op_valid <= 1'b0;
		end else begin
			op_valid <= pop;
			// spend and return in one cycle cancel out
			if (pop && !op_credit)
				credits <= credits - 1'b1;
			else if (!pop && op_credit)
				credits <= credits + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			op_class <= insn_class;
			op0 <= op0_d;
			op1 <= op1_d;
			op2 <= op2_d;
			carry <= carry_d;
		end
	end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

`include "decode_settings.svh"

module reg_file
	import arm_isa_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	input  reg_idx_t rd_idx0,
	input  reg_idx_t rd_idx1,
	input  reg_idx_t rd_idx2,
	input  word_t    r15_value,
	output word_t    rd_data0,
	output word_t    rd_data1,
	output word_t    rd_data2
);

	localparam reg_idx_t PC_IDX = reg_idx_t'(`DEC_NUM_REGS - 1);

	word_t regs [`DEC_NUM_REGS];

	// writeback port, the new value shows up after the edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `DEC_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// r15 is never read from the array
	assign rd_data0 = (rd_idx0 == PC_IDX) ? r15_value : regs[rd_idx0];
	assign rd_data1 = (rd_idx1 == PC_IDX) ? r15_value : regs[rd_idx1];
	assign rd_data2 = (rd_idx2 == PC_IDX) ? r15_value : regs[rd_idx2];

endmodule
